//--- dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/cache_way.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv

//--- test/mem_model.sv
// behavioural line memory for the cache testbench
// random ready delays, one outstanding read, write-backs absorbed
`timescale 1ns/1ps

module mem_model (
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       salt,
    input  logic              rd_req,
    input  dcache_pkg::addr_t rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output dcache_pkg::line_t ret_data,
    input  logic              wr_req,
    input  dcache_pkg::addr_t wr_addr,
    input  dcache_pkg::line_t wr_data,
    output logic              wr_rdy
);
    import dcache_pkg::*;

    word_t mem [addr_t];   // only words written back, by word address
    int    rd_wait;
    int    wr_wait;
    int    ret_wait;
    logic  ret_pend;
    logic  rd_take;
    logic  wr_take;
    addr_t rd_line;
    addr_t wr_line;
    line_t wr_line_data;

    // contents before any write-back, every address bit counts
    function automatic word_t init_word(addr_t a);
        return (a * 32'h9e3779b1) ^ {a[12:0], a[31:13]} ^ salt;
    endfunction

    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : init_word(a);
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        ret_pend  = 1'b0;
        rd_wait   = 0;
        wr_wait   = 0;
        ret_wait  = 0;
        forever begin
            @(negedge clk);
            // handshakes that complete at the coming edge
            rd_take = (rd_req === 1'b1) && rd_rdy;
            wr_take = (wr_req === 1'b1) && wr_rdy;
            if (rd_take) begin
                rd_line = rd_addr;
            end
            wr_line      = wr_addr;
            wr_line_data = wr_data;
            @(posedge clk);
            #1;
            if (reset) begin
                rd_rdy    = 1'b0;
                wr_rdy    = 1'b0;
                ret_valid = 1'b0;
                ret_pend  = 1'b0;
            end else begin
                ret_valid = 1'b0;
                if (wr_take) begin
                    for (int k = 0; k < 4; k++) begin
                        mem[wr_line + 4*k] = wr_line_data[32*k +: 32];
                    end
                    wr_rdy  = 1'b0;
                    wr_wait = $urandom % 6;
                end else if (wr_req === 1'b1 && !wr_rdy) begin
                    if (wr_wait == 0) wr_rdy = 1'b1;
                    else wr_wait--;
                end
                if (rd_take) begin
                    rd_rdy   = 1'b0;
                    rd_wait  = $urandom % 6;
                    ret_pend = 1'b1;
                    ret_wait = $urandom % 6;
                end else if (rd_req === 1'b1 && !rd_rdy) begin
                    if (rd_wait == 0) rd_rdy = 1'b1;
                    else rd_wait--;
                end
                if (ret_pend) begin
                    if (ret_wait == 0) begin
                        for (int k = 0; k < 4; k++) begin
                            ret_data[32*k +: 32] = read_word(rd_line + 4*k);
                        end
                        ret_valid = 1'b1;
                        ret_pend  = 1'b0;
                    end else begin
                        ret_wait--;
                    end
                end
            end
        end
    end

endmodule

//--- test/tb_dcache.sv
// testbench for the two-way data cache
// clock and reset, request driver, shadow memory with reference function,
// response checker, directed and random tests
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    typedef struct packed {
        logic        load;
        logic        hit;    // must answer one cycle after acceptance
        word_t       data;
        logic [31:0] cyc;
    } exp_t;

    logic        clk;
    logic        reset;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    addr_t       rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic        wr_req;
    addr_t       wr_addr;
    line_t       wr_data;
    logic        wr_rdy;
    logic [31:0] salt;

    word_t shadow [addr_t];
    exp_t  exp_q [$];
    int    errors = 0;
    int    cycle = 0;
    int    n_acc = 0;
    int    n_resp = 0;
    int    rd_count = 0;
    int    wr_count = 0;
    addr_t last_rd_addr;
    addr_t last_wr_addr;
    line_t last_wr_data;

    dcache_top i_dut (.*);
    mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic word_t shadow_word(addr_t wa);
        return shadow.exists(wa) ? shadow[wa] : u_mem.init_word(wa);
    endfunction

    // reference: apply a store's strobe to the shadow, return the current word
    function automatic word_t expected_word(logic op, addr_t a, strb_t s, word_t d);
        addr_t wa;
        word_t w;
        wa = {a[31:2], 2'b00};
        w = shadow_word(wa);
        if (op) begin
            for (int i = 0; i < 4; i++) begin
                if (s[i]) w[8*i +: 8] = d[8*i +: 8];
            end
        end
        shadow[wa] = w;
        return w;
    endfunction

    function automatic line_t shadow_line(addr_t a);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[32*k +: 32] = shadow_word({a[31:4], 4'h0} + 4*k);
        end
        return l;
    endfunction

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic stop_on_timeout(input string why);
        $display("timeout at %0t: %s", $time, why);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic test_done(input int num, input string name, input int err0);
        $display("test %0d %s: %0d errors", num, name, errors - err0);
    endtask

    // called 1 ns after a rising edge, returns at the same point
    task automatic send_request(input logic op, input addr_t a, input strb_t s,
                                input word_t d, input logic want_hit);
        cpu_req_t r;
        exp_t     e;
        int       n;
        r.op = op;
        {r.tag, r.index, r.offset} = a;
        r.wstrb = op ? s : 4'b0000;
        r.wdata = d;
        valid = 1'b1;
        req = r;
        n = 0;
        @(negedge clk);
        while (!addr_ok && n < 200) begin
            n++;
            @(negedge clk);
        end
        if (!addr_ok) begin
            stop_on_timeout("addr_ok stayed low for 200 cycles");
        end else begin
            e.load = !op;
            e.hit  = want_hit;
            e.data = expected_word(op, a, s, d);
            e.cyc  = cycle;
            exp_q.push_back(e);
            n_acc++;
            @(posedge clk);
            #1;
            valid = 1'b0;
        end
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            n++;
            @(posedge clk);
            #1;
        end
        if (exp_q.size() != 0) begin
            stop_on_timeout("data_ok missing for 200 cycles");
        end
    endtask

    // memory channel monitor and response checker
    always @(negedge clk) begin : check_resp
        exp_t e;
        if (!reset) begin
            if (rd_req && rd_rdy) begin
                rd_count++;
                last_rd_addr = rd_addr;
            end
            if (wr_req && wr_rdy) begin
                wr_count++;
                last_wr_addr = wr_addr;
                last_wr_data = wr_data;
            end
            if (data_ok) begin
                n_resp++;
                if (exp_q.size() == 0) begin
                    $display("FAIL t=%0t data_ok pulsed with no request outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (e.load && rdata !== e.data) value_error("rdata", rdata, e.data);
                    if (e.hit && cycle != e.cyc + 1) value_error("data_ok cycle", cycle, e.cyc + 1);
                end
            end
        end
    end

    initial begin
        int    err0;
        int    rd0;
        int    wr0;
        int    acc0;
        int    resp0;
        addr_t base;
        addr_t a;
        addr_t a1;
        addr_t a2;
        addr_t a3;
        strb_t strbs [4];
        tag_t  tags [4];
        index_t idxs [4];
        void'($urandom(32'h9a003f7e));
        salt  = $urandom;
        reset = 1'b1;
        valid = 1'b0;
        req   = '0;
        strbs = '{4'b0001, 4'b0011, 4'b1100, 4'b1111};
        tags  = '{20'h00010, 20'h00020, 20'h00030, 20'haa5c3};
        idxs  = '{8'h00, 8'h01, 8'h5d, 8'hf3};
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        err0 = errors;
        @(negedge clk);
        if (addr_ok !== 1'b1) value_error("addr_ok", addr_ok, 1);
        if (data_ok !== 1'b0) value_error("data_ok", data_ok, 0);
        if (rd_req !== 1'b0) value_error("rd_req", rd_req, 0);
        if (wr_req !== 1'b0) value_error("wr_req", wr_req, 0);
        @(posedge clk);
        #1;
        rd0 = rd_count;
        base = 32'h0001_2340;
        send_request(1'b0, base + 4, 4'h0, 0, 1'b0);
        wait_responses();
        if (rd_count != rd0 + 1) value_error("rd handshakes", rd_count - rd0, 1);
        if (last_rd_addr !== {base[31:4], 4'h0}) value_error("rd_addr", last_rd_addr, base);
        test_done(1, "reset state and first miss", err0);

        err0 = errors;
        rd0 = rd_count;
        for (int k = 0; k < 4; k++) send_request(1'b0, base + 4*k, 4'h0, 0, 1'b1);
        wait_responses();
        if (rd_count != rd0) value_error("rd handshakes", rd_count - rd0, 0);
        test_done(2, "back-to-back load hits", err0);

        err0 = errors;
        for (int k = 0; k < 4; k++) begin
            send_request(1'b1, base + 4*k, strbs[k], $urandom, 1'b1);
            send_request(1'b0, base + 4*k, 4'h0, 0, 1'b1);
        end
        wait_responses();
        test_done(3, "strobed store hits", err0);

        // index 5c, first tag dirty and least recently used
        err0 = errors;
        wr0 = wr_count;
        a1 = 32'h0004_15c0;
        a2 = 32'h0009_25c0;
        a3 = 32'h000e_35c0;
        send_request(1'b1, a1 + 4, 4'b1111, $urandom, 1'b0);
        send_request(1'b0, a2, 4'h0, 0, 1'b0);
        send_request(1'b0, a3 + 8, 4'h0, 0, 1'b0);
        wait_responses();
        if (wr_count != wr0 + 1) value_error("write-backs", wr_count - wr0, 1);
        if (last_wr_addr !== a1) value_error("wr_addr", last_wr_addr, a1);
        if (last_wr_data !== shadow_line(a1)) value_error("wr_data", last_wr_data, shadow_line(a1));
        send_request(1'b0, a2 + 12, 4'h0, 0, 1'b1);
        wait_responses();
        // index 71, touching the first tag moves eviction to the second
        wr0 = wr_count;
        a1 = 32'h0004_1710;
        a2 = 32'h0009_2710;
        a3 = 32'h000e_3710;
        send_request(1'b1, a1, 4'b0110, $urandom, 1'b0);
        send_request(1'b1, a2 + 4, 4'b1001, $urandom, 1'b0);
        send_request(1'b0, a1 + 8, 4'h0, 0, 1'b1);
        send_request(1'b0, a3, 4'h0, 0, 1'b0);
        wait_responses();
        if (wr_count != wr0 + 1) value_error("write-backs", wr_count - wr0, 1);
        if (last_wr_addr !== a2) value_error("wr_addr", last_wr_addr, a2);
        if (last_wr_data !== shadow_line(a2)) value_error("wr_data", last_wr_data, shadow_line(a2));
        send_request(1'b0, a1 + 12, 4'h0, 0, 1'b1);
        wait_responses();
        test_done(4, "LRU eviction and write-back", err0);

        err0 = errors;
        acc0 = n_acc;
        resp0 = n_resp;
        for (int i = 0; i < 400; i++) begin
            a = {tags[$urandom % 4], idxs[$urandom % 4], 2'($urandom % 4), 2'b00};
            send_request(1'($urandom % 2), a, 4'($urandom % 15 + 1), $urandom, 1'b0);
        end
        wait_responses();
        if (n_resp - resp0 != n_acc - acc0) begin
            value_error("data_ok count", n_resp - resp0, n_acc - acc0);
        end
        test_done(5, "random loads and stores", err0);

        $display("summary: %0d requests, %0d responses, %0d errors", n_acc, n_resp, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/cache_way.sv
// one cache way
// valid and dirty vectors, tag array, four 32-bit data banks
// synchronous read, per-bank write
`timescale 1ns/1ps
`include "dcache_config.svh"

module cache_way (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::index_t   rd_index,
    input  dcache_pkg::way_wr_t  wr,
    output dcache_pkg::way_out_t out
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0] dirty_q;
    tag_t  tag_mem [`DC_SETS];
    logic  valid_r;
    logic  dirty_r;
    tag_t  tag_r;
    word_t rd_word [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (|wr.ben) begin
            dirty_q[wr.index] <= wr.dirty;
            if (wr.tag_we) begin
                valid_q[wr.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.tag_we) begin
            tag_mem[wr.index] <= wr.tag;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
            dirty_r <= 1'b0;
        end else begin
            valid_r <= valid_q[rd_index];
            dirty_r <= dirty_q[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        tag_r <= tag_mem[rd_index];
    end

    for (genvar b = 0; b < 4; b++) begin : g_bank
        word_t mem [`DC_SETS];

        always_ff @(posedge clk) begin
            if (wr.ben[b]) begin
                mem[wr.index] <= wr.line[32*b +: 32];
            end
            rd_word[b] <= mem[rd_index];   // old data on a same-cycle write
        end
    end

    assign out = {valid_r, dirty_r, tag_r, rd_word[3], rd_word[2], rd_word[1], rd_word[0]};

    // refill must fill the whole line
    a_full_refill: assert property (@(posedge clk) disable iff (reset)
        wr.tag_we |-> &wr.ben);

endmodule

//--- verilog/dcache_config.svh
// size macros for the two-way data cache
// set count, address field widths and line width
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

`define DC_SETS      256
`define DC_INDEX_W   8
`define DC_TAG_W     20   // 32 - index - offset
`define DC_OFFSET_W  4

// four 32-bit banks per line
`define DC_LINE_W    128

`endif

//--- verilog/dcache_ctrl.sv
// data cache controller
// request buffer, FSM, hit check, LRU and victim choice,
// store merge, write-back and refill handshakes
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  dcache_pkg::line_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy,
    output dcache_pkg::index_t   rd_index,
    input  dcache_pkg::way_out_t way0_out,
    input  dcache_pkg::way_out_t way1_out,
    output dcache_pkg::way_wr_t  way0_wr,
    output dcache_pkg::way_wr_t  way1_wr
);
    import dcache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    cpu_req_t     req_q;
    logic         accept;
    logic         hit0;
    logic         hit1;
    logic         hit;
    line_t        hit_line;
    logic [`DC_SETS-1:0] lru_q;   // 1 = way1 is least recently used
    logic         victim;
    logic         victim_q;
    way_out_t     victim_out;
    logic         victim_dirty;
    way_wr_t      wr_c;
    logic [1:0]   wr_sel;

    // put the strobed bytes of r into word r.offset[3:2] of base
    function automatic line_t merge_line(line_t base, cpu_req_t r);
        line_t      res;
        logic [1:0] w;
        res = base;
        w = r.offset[3:2];
        for (int i = 0; i < 4; i++) begin
            if (r.wstrb[i]) begin
                res[32*w + 8*i +: 8] = r.wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    // way outputs belong to req_q.index in LOOKUP
    assign hit0 = way0_out.valid && (way0_out.tag == req_q.tag);
    assign hit1 = way1_out.valid && (way1_out.tag == req_q.tag);
    assign hit  = hit0 || hit1;
    assign hit_line = hit1 ? way1_out.line : way0_out.line;

    // no new lookup while a store bank write is pending
    assign addr_ok = (state_q == IDLE) || (state_q == LOOKUP && hit && !req_q.op);
    assign accept  = valid && addr_ok;
    assign data_ok = (state_q == LOOKUP) && hit;
    assign rdata   = hit_line[32*req_q.offset[3:2] +: 32];

    assign rd_index = accept ? req.index : req_q.index;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    state_d = MISS;
                end else if (!accept) begin
                    state_d = IDLE;
                end
            end
            MISS: begin
                if (!victim_dirty || wr_rdy) begin
                    state_d = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_d = RELOOK;
                end
            end
            RELOOK:  state_d = LOOKUP;   // reread after the refill write
            default: state_d = IDLE;
        endcase
    end

    // an invalid way first, otherwise the LRU way
    assign victim = !way0_out.valid ? 1'b0 :
                    !way1_out.valid ? 1'b1 : lru_q[req_q.index];

    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && !hit) begin
            victim_q <= victim;
        end
    end

    assign victim_out   = victim_q ? way1_out : way0_out;
    assign victim_dirty = victim_out.valid && victim_out.dirty;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (state_q == LOOKUP && hit) begin
            lru_q[req_q.index] <= hit0;
        end else if (state_q == REFILL && ret_valid) begin
            lru_q[req_q.index] <= !victim_q;
        end
    end

    // memory channels, held by the state until accepted
    assign wr_req  = (state_q == MISS) && victim_dirty;
    assign wr_addr = {victim_out.tag, req_q.index, {`DC_OFFSET_W{1'b0}}};
    assign wr_data = victim_out.line;
    assign rd_req  = (state_q == REPLACE);
    assign rd_addr = {req_q.tag, req_q.index, {`DC_OFFSET_W{1'b0}}};

    always_comb begin
        wr_c = '0;
        wr_sel = 2'b00;
        wr_c.index = req_q.index;
        wr_c.tag = req_q.tag;
        if (state_q == LOOKUP && hit && req_q.op) begin
            wr_c.ben   = 4'b0001 << req_q.offset[3:2];
            wr_c.dirty = 1'b1;
            wr_c.line  = merge_line(hit_line, req_q);
            wr_sel     = {hit1, hit0};
        end else if (state_q == REFILL && ret_valid) begin
            wr_c.ben    = 4'b1111;
            wr_c.tag_we = 1'b1;
            wr_c.dirty  = req_q.op;   // store miss leaves the line dirty
            wr_c.line   = req_q.op ? merge_line(ret_data, req_q) : ret_data;
            wr_sel      = victim_q ? 2'b10 : 2'b01;
        end
    end

    always_comb begin
        way0_wr = wr_c;
        way0_wr.ben = wr_c.ben & {4{wr_sel[0]}};
        way0_wr.tag_we = wr_c.tag_we && wr_sel[0];
        way1_wr = wr_c;
        way1_wr.ben = wr_c.ben & {4{wr_sel[1]}};
        way1_wr.tag_we = wr_c.tag_we && wr_sel[1];
    end

    // a set never holds the same tag in both ways
    a_one_hit_way: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> !(hit0 && hit1));

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data));

    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr));

endmodule

//--- verilog/dcache_pkg.sv
// shared types of the data cache
// address fields, data widths, request and way structs, controller states
package dcache_pkg;

`include "dcache_config.svh"

    typedef logic [31:0]              addr_t;
    typedef logic [`DC_TAG_W-1:0]     tag_t;
    typedef logic [`DC_INDEX_W-1:0]   index_t;
    typedef logic [`DC_OFFSET_W-1:0]  offset_t;
    typedef logic [31:0]              word_t;
    typedef logic [3:0]               strb_t;
    typedef logic [`DC_LINE_W-1:0]    line_t;   // word k at bits 32k and up

    // cpu request as accepted on valid && addr_ok
    typedef struct packed {
        logic    op;       // 1 = store
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    // one way, one cycle after rd_index
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_out_t;

    // write port of one way
    typedef struct packed {
        index_t     index;
        logic [3:0] ben;      // per bank
        logic       tag_we;   // refill, needs all banks
        tag_t       tag;
        logic       dirty;
        line_t      line;
    } way_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL,
        RELOOK
    } cache_state_e;

endpackage

//--- verilog/dcache_top.sv
// data cache top level
// controller plus two way stores
`timescale 1ns/1ps

module dcache_top (
    input  logic                clk,
    input  logic                reset,
    // cpu side
    input  logic                valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    // line read channel
    output logic                rd_req,
    output dcache_pkg::addr_t   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  dcache_pkg::line_t   ret_data,
    // line write channel
    output logic                wr_req,
    output dcache_pkg::addr_t   wr_addr,
    output dcache_pkg::line_t   wr_data,
    input  logic                wr_rdy
);
    import dcache_pkg::*;

    index_t   rd_index;
    way_out_t way0_out;
    way_out_t way1_out;
    way_wr_t  way0_wr;
    way_wr_t  way1_wr;

    dcache_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .rd_index  (rd_index),
        .way0_out  (way0_out),
        .way1_out  (way1_out),
        .way0_wr   (way0_wr),
        .way1_wr   (way1_wr)
    );

    cache_way u_way0 (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .wr       (way0_wr),
        .out      (way0_out)
    );

    cache_way u_way1 (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .wr       (way1_wr),
        .out      (way1_out)
    );

endmodule
